/* list.f */
common/apb_periph_pkg.sv
src/periph_bus_decode.sv
gpio/apb_gpio_regs.sv
soc_ctrl/apb_soc_control.sv
adv_timer/apb_pwm_timer.sv
src/apb_periph_subsystem.sv
verification/tb_apb_periph_subsystem.sv

/* Makefile */
# Verilator build and run for the APB peripheral subsystem testbench

TOP := tb_apb_periph_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -sv --assert --timing -Wno-fatal -f list.f --top-module $(TOP) -o V$(TOP)

# Pass or fail is taken from the simulation output itself
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

/* verification/tb_apb_periph_subsystem.sv */
// Directed testbench for the APB peripheral subsystem
// Drives the top-level APB port through GPIO, SoC control, LLC counter,
// PWM and error-response tests and compares against expected values
`timescale 1ns/100ps
`default_nettype none

module tb_apb_periph_subsystem;
   import apb_periph_pkg::*;

   // The tests run for about 300 cycles
   localparam int          TIMEOUT_CYCLES = 5000;
   localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

   logic                  clk, rst_n;
   logic                  psel, penable, pwrite, pready, pslverr;
   logic [APB_ADDR_W-1:0] paddr;
   logic [APB_DATA_W-1:0] pwdata, prdata;
   logic [NUM_GPIO-1:0]   gpio_in, gpio_out, gpio_dir;
   logic                  cluster_rstn, cluster_sa_boot, cluster_fetch_en;
   logic [APB_DATA_W-1:0] llc_start, llc_end, llc_spm;
   logic                  rd_hit, rd_miss, wr_hit, wr_miss;
   logic [NUM_PWM_CH-1:0] pwm;

   int                    errors, checks, tests, cycles;
   logic [31:0]           lfsr_state = 32'd19;
   logic [NUM_GPIO-1:0]   exp_dir, exp_out;
   logic [APB_DATA_W-1:0] exp_win [3];

   apb_periph_subsystem u_apb_periph_subsystem (
      .clk_i (clk), .rst_n_i (rst_n),
      .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
      .paddr_i (paddr), .pwdata_i (pwdata),
      .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
      .gpio_in_i (gpio_in), .gpio_out_o (gpio_out), .gpio_dir_o (gpio_dir),
      .cluster_rstn_o (cluster_rstn), .cluster_en_sa_boot_o (cluster_sa_boot),
      .cluster_fetch_en_o (cluster_fetch_en),
      .llc_cache_addr_start_o (llc_start), .llc_cache_addr_end_o (llc_end),
      .llc_spm_addr_start_o (llc_spm),
      .llc_read_hit_i (rd_hit), .llc_read_miss_i (rd_miss),
      .llc_write_hit_i (wr_hit), .llc_write_miss_i (wr_miss),
      .pwm_o (pwm)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ------------------------------------------------------------
   // Random values and address helpers
   // ------------------------------------------------------------
   function automatic logic next_random_bit();
      logic out_bit;
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
         lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      return out_bit;
   endfunction

   function automatic logic [31:0] random_bits(input int nbits);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         value = {value[30:0], next_random_bit()};
      end
      return value;
   endfunction

   function automatic logic [APB_ADDR_W-1:0] reg_addr(input logic [3:0] slot,
                                                      input logic [3:0] offs);
      return (APB_ADDR_W'(slot) << SLOT_LSB) | (APB_ADDR_W'(offs) << 2);
   endfunction

   // ------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------
   task automatic check_data(input string name, input logic [APB_DATA_W-1:0] exp,
                             input logic [APB_DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bits(input string name, input logic [NUM_GPIO-1:0] exp,
                             input logic [NUM_GPIO-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_pwm(input string name, input logic [NUM_PWM_CH-1:0] exp,
                            input logic [NUM_PWM_CH-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int start);
      tests++;
      if (errors == start) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - start);
      end
   endtask

   // ------------------------------------------------------------
   // APB master
   // ------------------------------------------------------------
   // Setup cycle then access cycle with the response sampled mid access
   task automatic bus_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                               input logic [APB_DATA_W-1:0] wdata,
                               output logic [APB_DATA_W-1:0] rdata, output logic err);
      @(posedge clk);
      #2;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #2;
      penable = 1'b1;
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      if (pready !== 1'b1) begin
         $display("No pready in the access cycle at %0t, address %h", $time, addr);
         errors++;
      end
      @(posedge clk);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] data, input logic exp_err);
      logic [APB_DATA_W-1:0] rdata;
      logic                  err;
      bus_transfer(1'b1, addr, data, rdata, err);
      check_err($sformatf("pslverr_o write %h", addr), exp_err, err);
   endtask

   task automatic apb_read(input string name, input logic [APB_ADDR_W-1:0] addr,
                           input logic [APB_DATA_W-1:0] exp_data, input logic exp_err);
      logic [APB_DATA_W-1:0] rdata;
      logic                  err;
      bus_transfer(1'b0, addr, '0, rdata, err);
      check_err($sformatf("pslverr_o read %h", addr), exp_err, err);
      check_data(name, exp_data, rdata);
   endtask

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------
   task automatic test_gpio();
      logic [NUM_GPIO-1:0] pins;
      int                  start;
      start   = errors;
      exp_dir = random_bits(NUM_GPIO);
      exp_out = random_bits(NUM_GPIO);
      apb_write(reg_addr(SLOT_GPIO, GPIO_DIR), exp_dir, 1'b0);
      apb_write(reg_addr(SLOT_GPIO, GPIO_OUT), exp_out, 1'b0);
      apb_read("GPIO_DIR", reg_addr(SLOT_GPIO, GPIO_DIR), exp_dir, 1'b0);
      apb_read("GPIO_OUT", reg_addr(SLOT_GPIO, GPIO_OUT), exp_out, 1'b0);
      check_bits("gpio_dir_o", exp_dir, gpio_dir);
      check_bits("gpio_out_o", exp_out, gpio_out);
      pins    = random_bits(NUM_GPIO);
      gpio_in = pins;
      repeat (3) @(posedge clk);
      #2;
      apb_read("GPIO_IN", reg_addr(SLOT_GPIO, GPIO_IN), pins, 1'b0);
      // Read-only register whose writes are dropped quietly
      apb_write(reg_addr(SLOT_GPIO, GPIO_IN), ~pins, 1'b0);
      apb_read("GPIO_IN after write", reg_addr(SLOT_GPIO, GPIO_IN), pins, 1'b0);
      check_bits("gpio_dir_o", exp_dir, gpio_dir);
      check_bits("gpio_out_o", exp_out, gpio_out);
      report_test("gpio", start);
   endtask

   task automatic test_soc_ctrl();
      int start;
      start = errors;
      check_data("cluster outputs", 32'd0,
                 {29'd0, cluster_fetch_en, cluster_sa_boot, cluster_rstn});
      apb_read("LLC_CACHE_START", reg_addr(SLOT_SOCCTRL, LLC_CACHE_START),
               LLC_CACHE_START_RST, 1'b0);
      apb_read("LLC_CACHE_END", reg_addr(SLOT_SOCCTRL, LLC_CACHE_END), LLC_CACHE_END_RST, 1'b0);
      apb_read("LLC_SPM_START", reg_addr(SLOT_SOCCTRL, LLC_SPM_START), LLC_SPM_START_RST, 1'b0);
      // One bit at a time so each control output is tied to its own bit
      for (int b = 0; b < 3; b++) begin
         apb_write(reg_addr(SLOT_SOCCTRL, CTRL_CLUSTER), 32'(1 << b), 1'b0);
         apb_read("CTRL_CLUSTER", reg_addr(SLOT_SOCCTRL, CTRL_CLUSTER), 32'(1 << b), 1'b0);
         check_data("cluster outputs", 32'(1 << b),
                    {29'd0, cluster_fetch_en, cluster_sa_boot, cluster_rstn});
      end
      for (int i = 0; i < 3; i++) begin
         exp_win[i] = random_bits(APB_DATA_W);
         apb_write(reg_addr(SLOT_SOCCTRL, 4'(LLC_CACHE_START + i)), exp_win[i], 1'b0);
         apb_read($sformatf("LLC window %0d", i),
                  reg_addr(SLOT_SOCCTRL, 4'(LLC_CACHE_START + i)), exp_win[i], 1'b0);
      end
      check_data("llc_cache_addr_start_o", exp_win[0], llc_start);
      check_data("llc_cache_addr_end_o", exp_win[1], llc_end);
      check_data("llc_spm_addr_start_o", exp_win[2], llc_spm);
      report_test("soc_ctrl", start);
   endtask

   task automatic test_llc_counters();
      int count [4];
      int most;
      int start;
      start = errors;
      most  = 0;
      for (int i = 0; i < 4; i++) begin
         count[i] = int'(random_bits(5));
         if (count[i] == 0) begin
            count[i] = 1;
         end
         if (count[i] > most) begin
            most = count[i];
         end
      end
      // Each event input stays high for its own number of cycles
      for (int c = 0; c < most; c++) begin
         rd_hit  = (c < count[0]);
         rd_miss = (c < count[1]);
         wr_hit  = (c < count[2]);
         wr_miss = (c < count[3]);
         @(posedge clk);
         #2;
      end
      {rd_hit, rd_miss, wr_hit, wr_miss} = 4'b0000;
      for (int i = 0; i < 4; i++) begin
         apb_read($sformatf("LLC counter %0d", i), reg_addr(SLOT_SOCCTRL, 4'(CNT_RD_HIT + i)),
                  32'(count[i]), 1'b0);
      end
      apb_write(reg_addr(SLOT_SOCCTRL, CNT_WR_HIT), random_bits(32), 1'b0);
      count[2] = 0;
      for (int i = 0; i < 4; i++) begin
         apb_read($sformatf("LLC counter %0d after clear", i),
                  reg_addr(SLOT_SOCCTRL, 4'(CNT_RD_HIT + i)), 32'(count[i]), 1'b0);
      end
      report_test("llc_counters", start);
   endtask

   task automatic test_pwm();
      logic [PWM_CNT_W-1:0] duty [4];
      int                   high [4];
      int                   start;
      start = errors;
      duty  = '{16'd3, 16'd0, 16'd10, 16'd7};
      high  = '{default: 0};
      apb_write(reg_addr(SLOT_PWM, PWM_PERIOD), 32'd10, 1'b0);
      for (int n = 0; n < NUM_PWM_CH; n++) begin
         apb_write(reg_addr(SLOT_PWM, 4'(PWM_DUTY0 + n)), 32'(duty[n]), 1'b0);
      end
      apb_write(reg_addr(SLOT_PWM, PWM_CTRL), 32'd1, 1'b0);
      // Five full periods of 10 cycles
      repeat (50) begin
         @(negedge clk);
         for (int n = 0; n < NUM_PWM_CH; n++) begin
            if (pwm[n]) begin
               high[n]++;
            end
         end
      end
      for (int n = 0; n < NUM_PWM_CH; n++) begin
         check_data($sformatf("pwm_o[%0d] high cycles", n),
                    32'(5 * ((duty[n] > 16'd10) ? 10 : int'(duty[n]))), 32'(high[n]));
      end
      apb_write(reg_addr(SLOT_PWM, PWM_CTRL), 32'd0, 1'b0);
      check_pwm("pwm_o", '0, pwm);
      report_test("pwm", start);
   endtask

   task automatic test_errors();
      int start;
      start = errors;
      apb_write(reg_addr(4'h7, GPIO_DIR), random_bits(32), 1'b1);
      apb_read("unmapped slot", reg_addr(4'h7, GPIO_DIR), 32'd0, 1'b1);
      apb_write(reg_addr(SLOT_GPIO, 4'hF), random_bits(32), 1'b1);
      apb_read("GPIO bad offset", reg_addr(SLOT_GPIO, 4'hF), 32'd0, 1'b1);
      apb_write(reg_addr(SLOT_SOCCTRL, 4'hF), random_bits(32), 1'b1);
      apb_read("SoC bad offset", reg_addr(SLOT_SOCCTRL, 4'hF), 32'd0, 1'b1);
      apb_write(reg_addr(SLOT_PWM, 4'hF), random_bits(32), 1'b1);
      apb_read("PWM bad offset", reg_addr(SLOT_PWM, 4'hF), 32'd0, 1'b1);
      apb_read("GPIO_DIR kept", reg_addr(SLOT_GPIO, GPIO_DIR), exp_dir, 1'b0);
      apb_read("LLC_CACHE_START kept", reg_addr(SLOT_SOCCTRL, LLC_CACHE_START), exp_win[0], 1'b0);
      apb_read("PWM_PERIOD kept", reg_addr(SLOT_PWM, PWM_PERIOD), 32'd10, 1'b0);
      report_test("errors", start);
   endtask

   // ------------------------------------------------------------
   // Run control
   // ------------------------------------------------------------
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      errors  = 0;
      checks  = 0;
      tests   = 0;
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      gpio_in = '0;
      {rd_hit, rd_miss, wr_hit, wr_miss} = 4'b0000;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      test_gpio();
      test_soc_ctrl();
      test_llc_counters();
      test_pwm();
      test_errors();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src/apb_periph_subsystem.sv */
// Top level of the APB peripheral subsystem
// One APB slave port is split by address slot into GPIO, SoC control and
// PWM timer register blocks, all on a single clock
`timescale 1ns/100ps
`default_nettype none

module apb_periph_subsystem (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  psel_i,
   input  logic                                  penable_i,
   input  logic                                  pwrite_i,
   input  logic [apb_periph_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [apb_periph_pkg::APB_DATA_W-1:0] pwdata_i,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                                  pready_o,
   output logic                                  pslverr_o,
   input  logic [apb_periph_pkg::NUM_GPIO-1:0]   gpio_in_i,
   output logic [apb_periph_pkg::NUM_GPIO-1:0]   gpio_out_o,
   output logic [apb_periph_pkg::NUM_GPIO-1:0]   gpio_dir_o,
   output logic                                  cluster_rstn_o,
   output logic                                  cluster_en_sa_boot_o,
   output logic                                  cluster_fetch_en_o,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] llc_cache_addr_start_o,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] llc_cache_addr_end_o,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] llc_spm_addr_start_o,
   input  logic                                  llc_read_hit_i,
   input  logic                                  llc_read_miss_i,
   input  logic                                  llc_write_hit_i,
   input  logic                                  llc_write_miss_i,
   output logic [apb_periph_pkg::NUM_PWM_CH-1:0] pwm_o
);
   import apb_periph_pkg::*;

   logic                  gpio_sel,    soc_sel,    pwm_sel;
   logic [APB_DATA_W-1:0] gpio_rdata,  soc_rdata,  pwm_rdata;
   logic                  gpio_ready,  soc_ready,  pwm_ready;
   logic                  gpio_slverr, soc_slverr, pwm_slverr;

   // ------------------------------------------------------------
   // Address decode and response mux
   // ------------------------------------------------------------
   periph_bus_decode u_periph_bus_decode (
      .psel_i        (psel_i),
      .paddr_i       (paddr_i),
      .gpio_sel_o    (gpio_sel),
      .soc_sel_o     (soc_sel),
      .pwm_sel_o     (pwm_sel),
      .gpio_rdata_i  (gpio_rdata),
      .soc_rdata_i   (soc_rdata),
      .pwm_rdata_i   (pwm_rdata),
      .gpio_ready_i  (gpio_ready),
      .soc_ready_i   (soc_ready),
      .pwm_ready_i   (pwm_ready),
      .gpio_slverr_i (gpio_slverr),
      .soc_slverr_i  (soc_slverr),
      .pwm_slverr_i  (pwm_slverr),
      .prdata_o      (prdata_o),
      .pready_o      (pready_o),
      .pslverr_o     (pslverr_o)
   );

   // ------------------------------------------------------------
   // Peripherals
   // ------------------------------------------------------------
   apb_gpio_regs u_apb_gpio_regs (
      .clk_i, .rst_n_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
      .psel_i     (gpio_sel),
      .prdata_o   (gpio_rdata),
      .pready_o   (gpio_ready),
      .pslverr_o  (gpio_slverr),
      .gpio_in_i, .gpio_out_o, .gpio_dir_o
   );

   apb_soc_control u_apb_soc_control (
      .clk_i, .rst_n_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
      .psel_i     (soc_sel),
      .prdata_o   (soc_rdata),
      .pready_o   (soc_ready),
      .pslverr_o  (soc_slverr),
      .cluster_rstn_o, .cluster_en_sa_boot_o, .cluster_fetch_en_o,
      .llc_cache_addr_start_o, .llc_cache_addr_end_o, .llc_spm_addr_start_o,
      .llc_read_hit_i, .llc_read_miss_i, .llc_write_hit_i, .llc_write_miss_i
   );

   apb_pwm_timer u_apb_pwm_timer (
      .clk_i, .rst_n_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
      .psel_i     (pwm_sel),
      .prdata_o   (pwm_rdata),
      .pready_o   (pwm_ready),
      .pslverr_o  (pwm_slverr),
      .pwm_o
   );

endmodule

`default_nettype wire

/* adv_timer/apb_pwm_timer.sv */
// Four-channel PWM timer on the APB bus
// A shared counter runs 0 to PERIOD-1 while enabled
// Channel n is high while the counter is below DUTYn
`timescale 1ns/100ps
`default_nettype none

module apb_pwm_timer (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  psel_i,
   input  logic                                  penable_i,
   input  logic                                  pwrite_i,
   input  logic [apb_periph_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [apb_periph_pkg::APB_DATA_W-1:0] pwdata_i,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                                  pready_o,
   output logic                                  pslverr_o,
   output logic [apb_periph_pkg::NUM_PWM_CH-1:0] pwm_o
);
   import apb_periph_pkg::*;

   pwm_reg_e             reg_sel;
   logic                 access;
   logic                 wr_en;
   logic                 reg_hit;
   logic                 duty_sel;
   logic [PWM_IDX_W-1:0] duty_idx;
   logic                 en_q;
   logic [PWM_CNT_W-1:0] period_q;
   logic [PWM_CNT_W-1:0] duty_q [NUM_PWM_CH];
   logic [PWM_CNT_W-1:0] cnt_q;

   assign reg_sel   = pwm_reg_e'(paddr_i[OFFS_LSB +: OFFS_W]);
   assign access    = psel_i && penable_i;
   assign wr_en     = access && pwrite_i;
   assign pready_o  = access;
   assign pslverr_o = access && !reg_hit;
   assign duty_sel  = reg_sel inside {PWM_DUTY0, PWM_DUTY1, PWM_DUTY2, PWM_DUTY3};
   assign duty_idx  = PWM_IDX_W'(reg_sel - PWM_DUTY0);

   always_comb begin
      reg_hit  = 1'b1;
      prdata_o = '0;
      if (reg_sel == PWM_CTRL) begin
         prdata_o = APB_DATA_W'(en_q);
      end else if (reg_sel == PWM_PERIOD) begin
         prdata_o = APB_DATA_W'(period_q);
      end else if (duty_sel) begin
         prdata_o = APB_DATA_W'(duty_q[duty_idx]);
      end else begin
         reg_hit = 1'b0;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         en_q     <= 1'b0;
         period_q <= '0;
         duty_q   <= '{default: '0};
      end else if (wr_en) begin
         if (reg_sel == PWM_CTRL) begin
            en_q <= pwdata_i[0];
         end
         if (reg_sel == PWM_PERIOD) begin
            period_q <= pwdata_i[PWM_CNT_W-1:0];
         end
         if (duty_sel) begin
            duty_q[duty_idx] <= pwdata_i[PWM_CNT_W-1:0];
         end
      end
   end

   // ------------------------------------------------------------
   // Period counter and compare outputs
   // ------------------------------------------------------------
   // The >= compare also recovers when PERIOD is lowered below the count
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (!en_q || (period_q == '0)) begin
         cnt_q <= '0;
      end else if (cnt_q >= period_q - 1'b1) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   always_comb begin
      for (int n = 0; n < NUM_PWM_CH; n++) begin
         pwm_o[n] = en_q && (cnt_q < duty_q[n]);
      end
   end

   // Allow one cycle for the counter to wrap after PERIOD is rewritten
   cnt_below_period_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      en_q && (period_q != '0) && $stable(period_q) |-> cnt_q < period_q);

endmodule

`default_nettype wire

/* soc_ctrl/apb_soc_control.sv */
// SoC control register slave
// Cluster reset, boot and fetch bits, the LLC address window and four
// saturating LLC event counters that clear on write
`timescale 1ns/100ps
`default_nettype none

module apb_soc_control (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  psel_i,
   input  logic                                  penable_i,
   input  logic                                  pwrite_i,
   input  logic [apb_periph_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [apb_periph_pkg::APB_DATA_W-1:0] pwdata_i,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                                  pready_o,
   output logic                                  pslverr_o,
   output logic                                  cluster_rstn_o,
   output logic                                  cluster_en_sa_boot_o,
   output logic                                  cluster_fetch_en_o,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] llc_cache_addr_start_o,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] llc_cache_addr_end_o,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] llc_spm_addr_start_o,
   input  logic                                  llc_read_hit_i,
   input  logic                                  llc_read_miss_i,
   input  logic                                  llc_write_hit_i,
   input  logic                                  llc_write_miss_i
);
   import apb_periph_pkg::*;

   socctrl_reg_e         reg_sel;
   logic                 access;
   logic                 wr_en;
   logic                 reg_hit;
   logic                 cnt_sel;
   logic [2:0]           ctrl_q;
   logic [LLC_NUM_CNT-1:0] llc_evt;
   logic [LLC_NUM_CNT-1:0] cnt_clr;
   logic [LLC_CNT_W-1:0] cnt_q [LLC_NUM_CNT];

   assign reg_sel   = socctrl_reg_e'(paddr_i[OFFS_LSB +: OFFS_W]);
   assign access    = psel_i && penable_i;
   assign wr_en     = access && pwrite_i;
   assign pready_o  = access;
   assign pslverr_o = access && !reg_hit;
   assign cnt_sel   = reg_sel inside {CNT_RD_HIT, CNT_RD_MISS, CNT_WR_HIT, CNT_WR_MISS};
   assign llc_evt   = {llc_write_miss_i, llc_write_hit_i, llc_read_miss_i, llc_read_hit_i};

   // Bit 0 releases the cluster reset
   assign cluster_rstn_o       = ctrl_q[0];
   assign cluster_en_sa_boot_o = ctrl_q[1];
   assign cluster_fetch_en_o   = ctrl_q[2];

   always_comb begin
      reg_hit  = 1'b1;
      prdata_o = '0;
      case (reg_sel)
         CTRL_CLUSTER:    prdata_o = APB_DATA_W'(ctrl_q);
         LLC_CACHE_START: prdata_o = llc_cache_addr_start_o;
         LLC_CACHE_END:   prdata_o = llc_cache_addr_end_o;
         LLC_SPM_START:   prdata_o = llc_spm_addr_start_o;
         CNT_RD_HIT, CNT_RD_MISS, CNT_WR_HIT, CNT_WR_MISS:
            prdata_o = APB_DATA_W'(cnt_q[reg_sel[1:0]]);
         default:         reg_hit  = 1'b0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q                 <= '0;
         llc_cache_addr_start_o <= LLC_CACHE_START_RST;
         llc_cache_addr_end_o   <= LLC_CACHE_END_RST;
         llc_spm_addr_start_o   <= LLC_SPM_START_RST;
      end else if (wr_en) begin
         case (reg_sel)
            CTRL_CLUSTER:    ctrl_q                 <= pwdata_i[2:0];
            LLC_CACHE_START: llc_cache_addr_start_o <= pwdata_i;
            LLC_CACHE_END:   llc_cache_addr_end_o   <= pwdata_i;
            LLC_SPM_START:   llc_spm_addr_start_o   <= pwdata_i;
            default:         ;
         endcase
      end
   end

   // ------------------------------------------------------------
   // LLC event counters
   // ------------------------------------------------------------
   always_comb begin
      cnt_clr = '0;
      if (wr_en && cnt_sel) begin
         cnt_clr[reg_sel[1:0]] = 1'b1;
      end
   end

   for (genvar i = 0; i < LLC_NUM_CNT; i++) begin : g_cnt
      // Clear wins over a same-cycle event
      // The count sticks at all ones
      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            cnt_q[i] <= '0;
         end else if (cnt_clr[i]) begin
            cnt_q[i] <= '0;
         end else if (llc_evt[i] && (cnt_q[i] != '1)) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
         end
      end

      cnt_monotonic_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         !$past(cnt_clr[i]) |-> cnt_q[i] >= $past(cnt_q[i]));
   end

endmodule

`default_nettype wire

/* gpio/apb_gpio_regs.sv */
// GPIO register slave on the APB bus
// DIR and OUT drive the pins directly
// GPIO_IN returns the input pins after a two-flop synchronizer
`timescale 1ns/100ps
`default_nettype none

module apb_gpio_regs (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  psel_i,
   input  logic                                  penable_i,
   input  logic                                  pwrite_i,
   input  logic [apb_periph_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [apb_periph_pkg::APB_DATA_W-1:0] pwdata_i,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                                  pready_o,
   output logic                                  pslverr_o,
   input  logic [apb_periph_pkg::NUM_GPIO-1:0]   gpio_in_i,
   output logic [apb_periph_pkg::NUM_GPIO-1:0]   gpio_out_o,
   output logic [apb_periph_pkg::NUM_GPIO-1:0]   gpio_dir_o
);
   import apb_periph_pkg::*;

   gpio_reg_e           reg_sel;
   logic                access;
   logic                reg_hit;
   logic [NUM_GPIO-1:0] in_meta;
   logic [NUM_GPIO-1:0] in_sync;

   assign reg_sel   = gpio_reg_e'(paddr_i[OFFS_LSB +: OFFS_W]);
   assign access    = psel_i && penable_i;
   assign pready_o  = access;
   assign pslverr_o = access && !reg_hit;

   // Unknown offsets read as zero and flag an error
   always_comb begin
      reg_hit  = 1'b1;
      prdata_o = '0;
      case (reg_sel)
         GPIO_DIR: prdata_o = APB_DATA_W'(gpio_dir_o);
         GPIO_OUT: prdata_o = APB_DATA_W'(gpio_out_o);
         GPIO_IN:  prdata_o = APB_DATA_W'(in_sync);
         default:  reg_hit  = 1'b0;
      endcase
   end

   // Writes to GPIO_IN fall through and are dropped
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gpio_dir_o <= '0;
         gpio_out_o <= '0;
      end else if (access && pwrite_i) begin
         case (reg_sel)
            GPIO_DIR: gpio_dir_o <= pwdata_i[NUM_GPIO-1:0];
            GPIO_OUT: gpio_out_o <= pwdata_i[NUM_GPIO-1:0];
            default:  ;
         endcase
      end
   end

   // Input synchronizer
   always_ff @(posedge clk_i) begin
      in_meta <= gpio_in_i;
      in_sync <= in_meta;
   end

   // Writes to the input register never disturb the pin registers
   gpio_in_wr_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      access && pwrite_i && (reg_sel == GPIO_IN) |=>
         $stable(gpio_dir_o) && $stable(gpio_out_o));

endmodule

`default_nettype wire

/* src/periph_bus_decode.sv */
// APB address decoder for the peripheral slots
// Gates psel into one select per peripheral and muxes the responses back
// Unmapped slots get an error response from here
`timescale 1ns/100ps
`default_nettype none

module periph_bus_decode (
   input  logic                                  psel_i,
   input  logic [apb_periph_pkg::APB_ADDR_W-1:0] paddr_i,
   output logic                                  gpio_sel_o,
   output logic                                  soc_sel_o,
   output logic                                  pwm_sel_o,
   input  logic [apb_periph_pkg::APB_DATA_W-1:0] gpio_rdata_i,
   input  logic [apb_periph_pkg::APB_DATA_W-1:0] soc_rdata_i,
   input  logic [apb_periph_pkg::APB_DATA_W-1:0] pwm_rdata_i,
   input  logic                                  gpio_ready_i,
   input  logic                                  soc_ready_i,
   input  logic                                  pwm_ready_i,
   input  logic                                  gpio_slverr_i,
   input  logic                                  soc_slverr_i,
   input  logic                                  pwm_slverr_i,
   output logic [apb_periph_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                                  pready_o,
   output logic                                  pslverr_o
);
   import apb_periph_pkg::*;

   periph_slot_e slot;

   assign slot       = periph_slot_e'(paddr_i[SLOT_LSB +: SLOT_W]);
   assign gpio_sel_o = psel_i && (slot == SLOT_GPIO);
   assign soc_sel_o  = psel_i && (slot == SLOT_SOCCTRL);
   assign pwm_sel_o  = psel_i && (slot == SLOT_PWM);

   always_comb begin
      case (slot)
         SLOT_GPIO: begin
            prdata_o  = gpio_rdata_i;
            pready_o  = gpio_ready_i;
            pslverr_o = gpio_slverr_i;
         end
         SLOT_SOCCTRL: begin
            prdata_o  = soc_rdata_i;
            pready_o  = soc_ready_i;
            pslverr_o = soc_slverr_i;
         end
         SLOT_PWM: begin
            prdata_o  = pwm_rdata_i;
            pready_o  = pwm_ready_i;
            pslverr_o = pwm_slverr_i;
         end
         default: begin
            // Unmapped slot answers at once with an error
            prdata_o  = '0;
            pready_o  = psel_i;
            pslverr_o = psel_i;
         end
      endcase
   end

   // A slave may only answer a transfer that selects it
   resp_needs_sel_a: assert final (psel_i || !(pready_o || pslverr_o))
      else $error("peripheral response without a select");

endmodule

`default_nettype wire

/* common/apb_periph_pkg.sv */
// Shared definitions for the APB peripheral subsystem
// Holds bus widths, the slot address map, register offset enums and the
// reset values of the LLC window registers
`default_nettype none

package apb_periph_pkg;

   // ------------------------------------------------------------
   // Bus and block widths
   // ------------------------------------------------------------
   localparam int unsigned APB_ADDR_W  = 32;
   localparam int unsigned APB_DATA_W  = 32;
   localparam int unsigned NUM_GPIO    = 32;
   localparam int unsigned NUM_PWM_CH  = 4;
   localparam int unsigned PWM_IDX_W   = $clog2(NUM_PWM_CH);
   localparam int unsigned PWM_CNT_W   = 16;
   localparam int unsigned LLC_CNT_W   = 32;
   localparam int unsigned LLC_NUM_CNT = 4;

   // Slot field picks the peripheral and word offset picks the register
   localparam int unsigned SLOT_LSB = 12;
   localparam int unsigned SLOT_W   = 4;
   localparam int unsigned OFFS_LSB = 2;
   localparam int unsigned OFFS_W   = 4;

   // ------------------------------------------------------------
   // Address map and register offsets
   // ------------------------------------------------------------
   typedef enum logic [SLOT_W-1:0] {
      SLOT_GPIO    = 4'd0,
      SLOT_SOCCTRL = 4'd1,
      SLOT_PWM     = 4'd2
   } periph_slot_e;

   typedef enum logic [OFFS_W-1:0] {
      GPIO_DIR = 4'd0,
      GPIO_OUT = 4'd1,
      GPIO_IN  = 4'd2
   } gpio_reg_e;

   // Counter offsets keep their index in the two low bits
   typedef enum logic [OFFS_W-1:0] {
      CTRL_CLUSTER    = 4'd0,
      LLC_CACHE_START = 4'd1,
      LLC_CACHE_END   = 4'd2,
      LLC_SPM_START   = 4'd3,
      CNT_RD_HIT      = 4'd4,
      CNT_RD_MISS     = 4'd5,
      CNT_WR_HIT      = 4'd6,
      CNT_WR_MISS     = 4'd7
   } socctrl_reg_e;

   typedef enum logic [OFFS_W-1:0] {
      PWM_CTRL   = 4'd0,
      PWM_PERIOD = 4'd1,
      PWM_DUTY0  = 4'd2,
      PWM_DUTY1  = 4'd3,
      PWM_DUTY2  = 4'd4,
      PWM_DUTY3  = 4'd5
   } pwm_reg_e;

   // LLC window defaults
   localparam logic [APB_DATA_W-1:0] LLC_CACHE_START_RST = 32'h8000_0000;
   localparam logic [APB_DATA_W-1:0] LLC_CACHE_END_RST   = 32'h8010_0000;
   localparam logic [APB_DATA_W-1:0] LLC_SPM_START_RST   = 32'h8010_0000;

endpackage

`default_nettype wire
